// File: vlog.f
+incdir+include
hdl/tlu_pkg.sv
hdl/tlu_serial_capture.sv
hdl/tlu_handshake_fsm.sv
hdl/trigger_word_fifo.sv
hdl/tlu_controller.sv
test/tlu_controller_tb.sv

// File: include/tlu_tb_model.svh
// TLU model tasks for the testbench: trigger pulse, serial number readout, expected word
`ifndef TLU_TB_MODEL_SVH
`define TLU_TB_MODEL_SVH

// expected word for a readout of bits clock cycles, 0 selects a full readout
function automatic logic [31:0] tlu_model_word(input logic [14:0] number, input int bits,
                                               input logic accept_err, input logic timeout_err);
    logic [31:0] word;
    int n;
    n = (bits == 0) ? tlu_pkg::MAX_CLOCK_CYCLES : bits;
    word = '0;
    word[tlu_pkg::WORD_MARKER_BIT] = 1'b1;
    word[tlu_pkg::ACCEPT_ERROR_BIT] = accept_err;
    word[tlu_pkg::TIMEOUT_ERROR_BIT] = timeout_err;
    for (int i = 0; i < tlu_pkg::TRIGGER_NUMBER_WIDTH; i++)
    begin
        if (i < n - 1)
            word[i] = number[i];
    end
    return word;
endfunction

// raise the trigger, then answer each rising TLU clock with a dummy bit and the number;
// call on a falling CLK edge, signals are the testbench variables
task automatic tlu_model_trigger(ref logic clk, ref logic tlu_clock, ref logic tlu_trigger,
                                 input int high_cycles, input logic clocked, input int bits,
                                 input logic msb_first, input logic [14:0] number);
    int n;
    int sent;
    int high_left;
    logic clock_q;
    logic [30:0] value;
    n = (bits == 0) ? tlu_pkg::MAX_CLOCK_CYCLES : bits;
    value = 31'(number);
    sent = 0;
    high_left = high_cycles;
    clock_q = tlu_clock;
    tlu_trigger = 1'b1;
    while ((high_left > 0) || (clocked && (sent < n)))
    begin
        @(negedge clk);
        if (high_left > 0)
            high_left--;
        if (tlu_clock && !clock_q)
        begin
            if (sent == 0)
                tlu_trigger = 1'b0;
            else
                tlu_trigger = msb_first ? value[n - 1 - sent] : value[sent - 1];
            sent++;
        end
        else if (sent == 0)
            tlu_trigger = (high_left > 0);
        clock_q = tlu_clock;
    end
    // hold the last bit until it has been sampled
    if (clocked)
    begin
        while (tlu_clock)
            @(negedge clk);
        repeat (2) @(negedge clk);
        tlu_trigger = 1'b0;
    end
endtask

`endif

// File: test/tlu_controller_tb.sv
// testbench for the TLU controller: table of trigger cases checked against a TLU model

`timescale 1ns/1ns
`default_nettype none

module tlu_controller_tb;

    typedef struct packed {
        tlu_pkg::tlu_mode_t mode;
        logic [4:0]         cycles;
        logic               msb;
        logic [7:0]         timeout;
        logic [7:0]         high;
        logic [3:0]         ready_delay;
        logic               read;
    } stim_row_t;

    localparam int NUM_ROWS = 13;

    // mode, clock_cycles, msb_first, low_time_out, trigger high, cmd_ready delay, read
    localparam stim_row_t ROWS [NUM_ROWS] = '{
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd0,  1'b1, 8'd0, 8'd3,  4'd0, 1'b1},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd0,  1'b1, 8'd0, 8'd6,  4'd0, 1'b1},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd12, 1'b0, 8'd0, 8'd3,  4'd0, 1'b1},
        '{tlu_pkg::MODE_NO_HANDSHAKE,     5'd0,  1'b0, 8'd0, 8'd0,  4'd3, 1'b1},
        '{tlu_pkg::MODE_NO_HANDSHAKE_ALT, 5'd0,  1'b0, 8'd0, 8'd0,  4'd0, 1'b1},
        '{tlu_pkg::MODE_SIMPLE_HANDSHAKE, 5'd0,  1'b0, 8'd0, 8'd5,  4'd0, 1'b1},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd0,  1'b1, 8'd5, 8'd40, 4'd0, 1'b1},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd20, 1'b1, 8'd0, 8'd10, 4'd4, 1'b1},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd16, 1'b0, 8'd0, 8'd3,  4'd0, 1'b0},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd0,  1'b1, 8'd0, 8'd3,  4'd0, 1'b0},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd8,  1'b1, 8'd0, 8'd3,  4'd0, 1'b0},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd0,  1'b0, 8'd0, 8'd3,  4'd0, 1'b0},
        '{tlu_pkg::MODE_DATA_HANDSHAKE,   5'd0,  1'b1, 8'd0, 8'd3,  4'd0, 1'b1}
    };

    logic               CLK;
    logic               RESET;
    logic               tlu_trigger;
    logic               tlu_trigger_flag;
    tlu_pkg::tlu_mode_t tlu_mode;
    logic [7:0]         low_time_out;
    logic [4:0]         clock_cycles;
    logic               msb_first;
    logic               disable_veto;
    logic               ext_veto;
    logic               cmd_ready;
    logic               ext_start_enable;
    logic               fifo_read;
    logic               cmd_ext_start;
    logic               tlu_busy;
    logic               tlu_clock;
    logic               tlu_veto;
    logic               fifo_empty;
    logic [31:0]        fifo_data;

    int          start_count = 0;
    logic [31:0] expected_words [$];

    `include "tlu_tb_model.svh"

    tlu_controller tlu_controller_inst
    (
        .CLK(CLK), .RESET(RESET),
        .tlu_trigger(tlu_trigger), .tlu_trigger_flag(tlu_trigger_flag), .tlu_mode(tlu_mode),
        .low_time_out(low_time_out), .clock_cycles(clock_cycles), .msb_first(msb_first),
        .disable_veto(disable_veto), .ext_veto(ext_veto), .cmd_ready(cmd_ready),
        .ext_start_enable(ext_start_enable), .fifo_read(fifo_read),
        .cmd_ext_start(cmd_ext_start), .tlu_busy(tlu_busy), .tlu_clock(tlu_clock),
        .tlu_veto(tlu_veto), .fifo_empty(fifo_empty), .fifo_data(fifo_data)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
        else
        begin
            $display("Fail at %0t ns: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // one count per cycle of the start pulse
    always @(negedge CLK)
    begin
        if (cmd_ext_start)
            start_count++;
    end

    initial
    begin
        repeat (NUM_ROWS * (tlu_pkg::MAX_CLOCK_CYCLES * tlu_pkg::CLOCK_DIVISOR + 200))
            @(posedge CLK);
        $display("timeout waiting for DUT");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        stim_row_t   r;
        logic [14:0] number;
        logic        timeout_expected;
        logic        veto_expected;
        int          starts_before;

        void'($urandom(32'h6f370ad5));
        RESET = 1'b1;
        tlu_trigger = 1'b0;
        tlu_trigger_flag = 1'b0;
        tlu_mode = tlu_pkg::MODE_DATA_HANDSHAKE;
        low_time_out = 8'd0;
        clock_cycles = 5'd0;
        msb_first = 1'b1;
        disable_veto = 1'b0;
        ext_veto = 1'b0;
        cmd_ready = 1'b1;
        ext_start_enable = 1'b1;
        fifo_read = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        check_value("cmd_ext_start", cmd_ext_start, 1'b0);
        check_value("tlu_busy", tlu_busy, 1'b0);
        check_value("tlu_clock", tlu_clock, 1'b0);
        check_value("tlu_veto", tlu_veto, 1'b0);
        check_value("fifo_empty", fifo_empty, 1'b1);

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            r = ROWS[i];
            tlu_mode = r.mode;
            clock_cycles = r.cycles;
            msb_first = r.msb;
            low_time_out = r.timeout;
            @(negedge CLK);
            starts_before = start_count;
            if (r.mode == tlu_pkg::MODE_DATA_HANDSHAKE || r.mode == tlu_pkg::MODE_SIMPLE_HANDSHAKE)
            begin
                number = 15'($urandom);
                timeout_expected = (r.timeout != 0) &&
                                   (int'(r.high) > int'(r.ready_delay) + int'(r.timeout) + 1);
                // a delayed cmd_ready leaves the trigger high in idle
                cmd_ready = (r.ready_delay == 0);
                fork
                    tlu_model_trigger(CLK, tlu_clock, tlu_trigger, r.high,
                                      r.mode == tlu_pkg::MODE_DATA_HANDSHAKE, r.cycles, r.msb,
                                      number);
                    begin
                        repeat (r.ready_delay) @(negedge CLK);
                        cmd_ready = 1'b1;
                        @(negedge CLK);
                        check_value("cmd_ext_start", cmd_ext_start, 1'b1);
                    end
                join
                if (r.mode == tlu_pkg::MODE_DATA_HANDSHAKE)
                    expected_words.push_back(tlu_model_word(number, r.cycles,
                                             r.ready_delay != 0, timeout_expected));
            end
            else
            begin
                tlu_trigger_flag = 1'b1;
                @(negedge CLK);
                tlu_trigger_flag = 1'b0;
                check_value("cmd_ext_start", cmd_ext_start, 1'b1);
                // here cmd_ready is held low after the start
                if (r.ready_delay != 0)
                begin
                    cmd_ready = 1'b0;
                    repeat (r.ready_delay) @(negedge CLK);
                    check_value("tlu_busy", tlu_busy, 1'b1);
                    cmd_ready = 1'b1;
                end
            end

            // FIFO full, so the last word stays in the FSM
            if (expected_words.size() > tlu_pkg::FIFO_DEPTH)
            begin
                repeat (4) @(negedge CLK);
                check_value("tlu_busy", tlu_busy, 1'b1);
            end
            else
            begin
                while (tlu_busy)
                    @(negedge CLK);
            end

            if (r.read)
            begin
                while (expected_words.size() > 0)
                begin
                    while (fifo_empty)
                        @(negedge CLK);
                    check_value("fifo_data", fifo_data, expected_words[0]);
                    fifo_read = 1'b1;
                    @(negedge CLK);
                    fifo_read = 1'b0;
                    void'(expected_words.pop_front());
                end
                while (tlu_busy)
                    @(negedge CLK);
            end

            repeat (2) @(negedge CLK);
            check_value("cmd_ext_start count", start_count - starts_before, 1);
            check_value("fifo_empty", fifo_empty, expected_words.size() == 0);
            veto_expected = (expected_words.size() >= tlu_pkg::FIFO_NEAR_FULL_LEVEL) &&
                            !disable_veto;
            check_value("tlu_veto", tlu_veto, veto_expected);
            if (veto_expected)
            begin
                disable_veto = 1'b1;
                repeat (2) @(negedge CLK);
                check_value("tlu_veto", tlu_veto, 1'b0);
                disable_veto = 1'b0;
                repeat (2) @(negedge CLK);
                check_value("tlu_veto", tlu_veto, 1'b1);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/tlu_controller.sv
// TLU controller top: handshake FSM, serial capture and trigger word FIFO

`timescale 1ns/1ns
`default_nettype none

module tlu_controller
(
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           tlu_trigger,
    input  logic                           tlu_trigger_flag,
    input  tlu_pkg::tlu_mode_t             tlu_mode,
    input  logic [7:0]                     low_time_out,
    input  logic [4:0]                     clock_cycles,
    input  logic                           msb_first,
    input  logic                           disable_veto,
    input  logic                           ext_veto,
    input  logic                           cmd_ready,
    input  logic                           ext_start_enable,
    input  logic                           fifo_read,
    output logic                           cmd_ext_start,
    output logic                           tlu_busy,
    output logic                           tlu_clock,
    output logic                           tlu_veto,
    output logic                           fifo_empty,
    output logic [tlu_pkg::WORD_WIDTH-1:0] fifo_data
);

    logic                                     clock_run;
    logic                                     latch;
    logic                                     bit_done;
    logic [tlu_pkg::TRIGGER_NUMBER_WIDTH-1:0] trigger_number;
    logic                                     word_valid;
    logic [tlu_pkg::WORD_WIDTH-1:0]           word_data;
    logic                                     fifo_full;
    logic                                     fifo_near_full;

    tlu_handshake_fsm fsm_inst
    (
        .CLK(CLK), .RESET(RESET),
        .tlu_trigger(tlu_trigger), .tlu_trigger_flag(tlu_trigger_flag), .tlu_mode(tlu_mode),
        .low_time_out(low_time_out), .clock_cycles(clock_cycles),
        .disable_veto(disable_veto), .ext_veto(ext_veto),
        .cmd_ready(cmd_ready), .ext_start_enable(ext_start_enable),
        .bit_done(bit_done), .trigger_number(trigger_number),
        .fifo_full(fifo_full), .fifo_near_full(fifo_near_full),
        .clock_run(clock_run), .latch(latch),
        .word_valid(word_valid), .word_data(word_data),
        .cmd_ext_start(cmd_ext_start), .tlu_busy(tlu_busy), .tlu_veto(tlu_veto)
    );

    tlu_serial_capture capture_inst
    (
        .CLK(CLK), .RESET(RESET),
        .clock_run(clock_run), .latch(latch), .tlu_trigger(tlu_trigger),
        .msb_first(msb_first), .clock_cycles(clock_cycles),
        .tlu_clock(tlu_clock), .bit_done(bit_done), .trigger_number(trigger_number)
    );

    trigger_word_fifo fifo_inst
    (
        .CLK(CLK), .RESET(RESET),
        .write(word_valid), .read(fifo_read), .write_data(word_data),
        .read_data(fifo_data), .empty(fifo_empty), .full(fifo_full), .near_full(fifo_near_full)
    );

endmodule

`default_nettype wire

// File: hdl/trigger_word_fifo.sv
// first-word-fall-through FIFO of trigger words with full and near-full flags

`timescale 1ns/1ns
`default_nettype none

module trigger_word_fifo
(
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           write,
    input  logic                           read,
    input  logic [tlu_pkg::WORD_WIDTH-1:0] write_data,
    output logic [tlu_pkg::WORD_WIDTH-1:0] read_data,
    output logic                           empty,
    output logic                           full,
    output logic                           near_full
);

    logic [tlu_pkg::WORD_WIDTH-1:0]       mem [tlu_pkg::FIFO_DEPTH];
    logic [tlu_pkg::FIFO_ADDR_WIDTH-1:0]  wr_ptr;
    logic [tlu_pkg::FIFO_ADDR_WIDTH-1:0]  rd_ptr;
    logic [tlu_pkg::FIFO_COUNT_WIDTH-1:0] count;
    logic                                 do_write;
    logic                                 do_read;

    assign do_write = write && !full;
    assign do_read = read && !empty;

    assign empty = (count == 0);
    assign full = (count == tlu_pkg::FIFO_DEPTH);
    assign near_full = (count >= tlu_pkg::FIFO_NEAR_FULL_LEVEL);

    // head word is visible without a read
    assign read_data = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= write_data;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= (wr_ptr == tlu_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= (rd_ptr == tlu_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a word refused while full stays offered until it is taken
    write_held_while_full: assert property (@(posedge CLK) disable iff (RESET)
        (write && full) |=> write)
        else $error("trigger word dropped while FIFO full");

endmodule

`default_nettype wire

// File: hdl/tlu_handshake_fsm.sv
// TLU handshake controller FSM with busy, veto, error flags and trigger word assembly

`timescale 1ns/1ns
`default_nettype none

module tlu_handshake_fsm
(
    input  logic                                     CLK,
    input  logic                                     RESET,
    input  logic                                     tlu_trigger,
    input  logic                                     tlu_trigger_flag,
    input  tlu_pkg::tlu_mode_t                       tlu_mode,
    input  logic [7:0]                               low_time_out,
    input  logic [4:0]                               clock_cycles,
    input  logic                                     disable_veto,
    input  logic                                     ext_veto,
    input  logic                                     cmd_ready,
    input  logic                                     ext_start_enable,
    input  logic                                     bit_done,
    input  logic [tlu_pkg::TRIGGER_NUMBER_WIDTH-1:0] trigger_number,
    input  logic                                     fifo_full,
    input  logic                                     fifo_near_full,
    output logic                                     clock_run,
    output logic                                     latch,
    output logic                                     word_valid,
    output logic [tlu_pkg::WORD_WIDTH-1:0]           word_data,
    output logic                                     cmd_ext_start,
    output logic                                     tlu_busy,
    output logic                                     tlu_veto
);

    tlu_pkg::fsm_state_t state;
    tlu_pkg::fsm_state_t next_state;

    logic       data_mode;
    logic       handshake_mode;
    logic       start_cond;
    logic [5:0] n_bits;
    logic [5:0] bit_cnt;
    logic [7:0] wait_cnt;
    logic       timeout_error;
    logic       accept_error;
    logic       word_saved;
    logic       write_accept;
    logic       veto_state;
    logic       veto_cause;

    assign data_mode = (tlu_mode == tlu_pkg::MODE_DATA_HANDSHAKE);
    assign handshake_mode = data_mode || (tlu_mode == tlu_pkg::MODE_SIMPLE_HANDSHAKE);

    assign start_cond = cmd_ready && ext_start_enable && !ext_veto &&
                        (tlu_trigger_flag || (tlu_trigger && handshake_mode));

    assign n_bits = (clock_cycles == 5'd0) ? 6'(tlu_pkg::MAX_CLOCK_CYCLES) : {1'b0, clock_cycles};

    assign clock_run = (state == tlu_pkg::SEND_TLU_CLOCK);
    assign latch = (state == tlu_pkg::LATCH_DATA);

    // one word per data handshake, held until the FIFO takes it
    assign word_valid = (state == tlu_pkg::WAIT_DATA_SAVED) && data_mode && !word_saved;
    assign write_accept = word_valid && !fifo_full;

    assign veto_state = (next_state == tlu_pkg::IDLE) || (next_state == tlu_pkg::LATCH_DATA) ||
                        (next_state == tlu_pkg::WAIT_DATA_SAVED);
    assign veto_cause = !ext_start_enable || (fifo_near_full && !disable_veto);

    always_comb
    begin
        word_data = '0;
        word_data[tlu_pkg::WORD_MARKER_BIT] = 1'b1;
        word_data[tlu_pkg::ACCEPT_ERROR_BIT] = accept_error;
        word_data[tlu_pkg::TIMEOUT_ERROR_BIT] = timeout_error;
        word_data[tlu_pkg::TRIGGER_NUMBER_WIDTH-1:0] = trigger_number;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            tlu_pkg::IDLE:
            begin
                if (start_cond)
                    next_state = tlu_pkg::WAIT_TRIGGER_LOW;
            end
            tlu_pkg::WAIT_TRIGGER_LOW:
            begin
                // modes 00 and 01 do not wait for the trigger to drop
                if (!handshake_mode)
                    next_state = tlu_pkg::WAIT_DATA_SAVED;
                else if (!tlu_trigger || timeout_error)
                    next_state = data_mode ? tlu_pkg::SEND_TLU_CLOCK : tlu_pkg::WAIT_DATA_SAVED;
            end
            tlu_pkg::SEND_TLU_CLOCK:
            begin
                if (bit_done && (bit_cnt == n_bits - 6'd1))
                    next_state = tlu_pkg::LATCH_DATA;
            end
            tlu_pkg::LATCH_DATA:
            begin
                next_state = tlu_pkg::WAIT_DATA_SAVED;
            end
            tlu_pkg::WAIT_DATA_SAVED:
            begin
                if (cmd_ready && (!data_mode || word_saved || write_accept))
                    next_state = tlu_pkg::IDLE;
            end
            default:
            begin
                next_state = tlu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= tlu_pkg::IDLE;
            cmd_ext_start <= 1'b0;
            tlu_busy <= 1'b0;
            tlu_veto <= 1'b0;
            wait_cnt <= '0;
            bit_cnt <= '0;
            timeout_error <= 1'b0;
            accept_error <= 1'b0;
            word_saved <= 1'b0;
        end
        else
        begin
            state <= next_state;
            cmd_ext_start <= (state == tlu_pkg::IDLE) && (next_state == tlu_pkg::WAIT_TRIGGER_LOW);
            tlu_busy <= (next_state != tlu_pkg::IDLE);
            tlu_veto <= veto_state && veto_cause;

            // trigger level seen in the idle cycle before a start
            if (next_state == tlu_pkg::IDLE)
                accept_error <= tlu_trigger;

            if (state == tlu_pkg::WAIT_TRIGGER_LOW)
            begin
                if (wait_cnt != 8'hff)
                    wait_cnt <= wait_cnt + 8'd1;
                if ((low_time_out != 8'd0) && (wait_cnt >= low_time_out) && tlu_trigger)
                    timeout_error <= 1'b1;
            end
            else
            begin
                wait_cnt <= '0;
                if (state == tlu_pkg::IDLE)
                    timeout_error <= 1'b0;
            end

            if (state != tlu_pkg::SEND_TLU_CLOCK)
                bit_cnt <= '0;
            else if (bit_done)
                bit_cnt <= bit_cnt + 6'd1;

            if (state != tlu_pkg::WAIT_DATA_SAVED)
                word_saved <= 1'b0;
            else if (write_accept)
                word_saved <= 1'b1;
        end
    end

    start_single_pulse: assert property (@(posedge CLK) disable iff (RESET)
        cmd_ext_start |=> !cmd_ext_start)
        else $error("cmd_ext_start high in two consecutive cycles");

    clock_only_when_busy: assert property (@(posedge CLK) disable iff (RESET)
        clock_run |-> tlu_busy)
        else $error("TLU clock running while not busy");

endmodule

`default_nettype wire

// File: hdl/tlu_serial_capture.sv
// TLU clock divider and serial trigger number capture with bit reordering

`timescale 1ns/1ns
`default_nettype none

module tlu_serial_capture
(
    input  logic                                     CLK,
    input  logic                                     RESET,
    input  logic                                     clock_run,
    input  logic                                     latch,
    input  logic                                     tlu_trigger,
    input  logic                                     msb_first,
    input  logic [4:0]                               clock_cycles,
    output logic                                     tlu_clock,
    output logic                                     bit_done,
    output logic [tlu_pkg::TRIGGER_NUMBER_WIDTH-1:0] trigger_number
);

    logic [tlu_pkg::CLOCK_COUNT_WIDTH-1:0] div_cnt;
    logic [tlu_pkg::MAX_CLOCK_CYCLES-1:0]  shift_reg;
    logic [5:0]                            n_bits;
    logic                                  sample;

    assign n_bits = (clock_cycles == 5'd0) ? 6'(tlu_pkg::MAX_CLOCK_CYCLES) : {1'b0, clock_cycles};

    // high for the first half of each period
    assign tlu_clock = clock_run && (div_cnt < tlu_pkg::CLOCK_DIVISOR / 2);

    // sample lands at the start of the last cycle of the period
    assign sample = clock_run && (div_cnt == tlu_pkg::CLOCK_DIVISOR - 2);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            div_cnt <= '0;
            bit_done <= 1'b0;
        end
        else
        begin
            bit_done <= sample;
            if (!clock_run || div_cnt == tlu_pkg::CLOCK_DIVISOR - 1)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // newest bit at position 0, first bit received at n_bits-1
    always_ff @(posedge CLK)
    begin
        if (sample)
            shift_reg <= {shift_reg[tlu_pkg::MAX_CLOCK_CYCLES-2:0], tlu_trigger};
    end

    // drop the dummy bit, keep n_bits-1 data bits, truncate to the field
    always_ff @(posedge CLK)
    begin
        if (latch)
        begin
            for (int i = 0; i < tlu_pkg::TRIGGER_NUMBER_WIDTH; i++)
            begin
                if (i < n_bits - 1)
                    trigger_number[i] <= msb_first ? shift_reg[i] : shift_reg[n_bits - 2 - i];
                else
                    trigger_number[i] <= 1'b0;
            end
        end
    end

    latch_outside_clocking: assert property (@(posedge CLK) disable iff (RESET)
        !(latch && clock_run))
        else $error("latch while TLU clock is running");

endmodule

`default_nettype wire

// File: hdl/tlu_pkg.sv
// TLU controller shared constants, field positions and encodings

`default_nettype none

package tlu_pkg;

    // CLK cycles per TLU clock period
    localparam int CLOCK_DIVISOR = 4;
    localparam int CLOCK_COUNT_WIDTH = $clog2(CLOCK_DIVISOR);

    // a clock_cycles setting of 0 selects a full readout
    localparam int MAX_CLOCK_CYCLES = 32;

    localparam int WORD_WIDTH = 32;
    localparam int TRIGGER_NUMBER_WIDTH = 15;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_NEAR_FULL_LEVEL = FIFO_DEPTH - 1;
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // trigger word flag bits
    localparam int WORD_MARKER_BIT = 31;
    localparam int ACCEPT_ERROR_BIT = 30;
    localparam int TIMEOUT_ERROR_BIT = 29;

    typedef enum logic [1:0] {
        MODE_NO_HANDSHAKE     = 2'b00,
        MODE_NO_HANDSHAKE_ALT = 2'b01,
        MODE_SIMPLE_HANDSHAKE = 2'b10,
        MODE_DATA_HANDSHAKE   = 2'b11
    } tlu_mode_t;

    typedef enum logic [2:0] {
        IDLE             = 3'd0,
        WAIT_TRIGGER_LOW = 3'd1,
        SEND_TLU_CLOCK   = 3'd2,
        LATCH_DATA       = 3'd3,
        WAIT_DATA_SAVED  = 3'd4
    } fsm_state_t;

endpackage

`default_nettype wire
